// File: ahbAddrDecoder.sv
`include "ahbMem_config.svh"

module ahbAddrDecoder
    import ahbPkg::*;
(
    input  ahbAddrPhase_t addrPhase,
    input  logic          HSEL,
    output logic          ramSel,
    output logic          defSel,
    output slaveSel_t     addrOwner
);

    localparam int regionBits = $clog2(`REGION_SIZE);
    localparam int ramBytes   = 2 ** `RAM_ADDR_WIDTH;

    logic                  active;
    logic [regionBits-1:0] regionOffset;
    logic [regionBits-1:0] ramOffset;
    logic                  ramHit;

    // Only NONSEQ and SEQ move data
    assign active = HSEL & (addrPhase.trans inside {NONSEQ, SEQ});

    assign regionOffset = addrPhase.addr[regionBits-1:0];   // Offset inside the region

    // Below the RAM base the subtraction wraps and misses the window
    assign ramOffset = regionOffset - regionBits'(`RAM_BASE);
    assign ramHit    = {1'b0, ramOffset} < (regionBits + 1)'(ramBytes);

    // Owner follows the address even when no transfer is active
    assign addrOwner = ramHit ? SEL_RAM : SEL_DEFAULT;

    assign ramSel = active & ramHit;
    assign defSel = active & ~ramHit;                        // Unmapped part of the region

endmodule

// File: ahbDefaultSlave.sv
module ahbDefaultSlave
    import ahbPkg::*;
(
    input  logic          HCLK,
    input  logic          HRESETn,
    input  ahbAddrPhase_t addrPhase,
    input  logic          sel,
    input  logic          HREADY,
    output ahbSlaveResp_t resp
);

    typedef enum logic [1:0] {
        DEF_IDLE,                   // OKAY, ready
        DEF_ERR1,                   // ERROR, not ready
        DEF_ERR2                    // ERROR, ready
    } defState_t;

    defState_t state;
    logic      accept;

    // Only active transfers start an error response
    assign accept = sel & HREADY & (addrPhase.trans inside {NONSEQ, SEQ});

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state <= DEF_IDLE;
        end else begin
            case (state)
                DEF_IDLE: begin
                    if (accept) begin
                        state <= DEF_ERR1;
                    end
                end
                DEF_ERR1: begin
                    state <= DEF_ERR2;
                end
                DEF_ERR2: begin
                    // Back-to-back unmapped accesses restart the sequence
                    state <= accept ? DEF_ERR1 : DEF_IDLE;
                end
                default: begin
                    state <= DEF_IDLE;
                end
            endcase
        end
    end

    assign resp.rdata    = '0;
    assign resp.readyOut = (state != DEF_ERR1);
    assign resp.resp     = (state != DEF_IDLE);    // High in both error cycles

endmodule

// File: ahbMemSubsystem.sv
module ahbMemSubsystem
    import ahbPkg::*;
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        HSEL,
    input  logic [31:0] HADDR,
    input  logic        HWRITE,
    input  logic [2:0]  HSIZE,
    input  logic [1:0]  HTRANS,
    input  logic [31:0] HWDATA,
    output logic [31:0] HRDATA,
    output logic        HREADY,
    output logic        HRESP
);

    ahbAddrPhase_t addrPhase;
    logic          ramSel;
    logic          defSel;
    slaveSel_t     addrOwner;
    ahbSlaveResp_t ramResp;
    ahbSlaveResp_t defResp;

    // Bundle the address-phase signals
    assign addrPhase.addr  = HADDR;
    assign addrPhase.write = HWRITE;
    assign addrPhase.size  = HSIZE;
    assign addrPhase.trans = htrans_t'(HTRANS);

    ahbAddrDecoder decoder (
        .addrPhase (addrPhase),
        .HSEL      (HSEL),
        .ramSel    (ramSel),
        .defSel    (defSel),
        .addrOwner (addrOwner)
    );

    ahbWaitRam ram (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .addrPhase (addrPhase),
        .sel       (ramSel),
        .HREADY    (HREADY),
        .HWDATA    (HWDATA),
        .resp      (ramResp)
    );

    ahbDefaultSlave defSlave (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .addrPhase (addrPhase),
        .sel       (defSel),
        .HREADY    (HREADY),
        .resp      (defResp)
    );

    // Data-phase stage drives the bus response
    ahbResponseMux respMux (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .addrOwner (addrOwner),
        .ramResp   (ramResp),
        .defResp   (defResp),
        .HRDATA    (HRDATA),
        .HREADY    (HREADY),
        .HRESP     (HRESP)
    );

endmodule

// File: ahbMem_config.svh
`ifndef AHBMEM_CONFIG_SVH
`define AHBMEM_CONFIG_SVH

// Memory map of the AHB-Lite memory region

// Byte-address bits seen by the RAM (64 words)
`define RAM_ADDR_WIDTH 8

// RAM start inside the region, aligned to the RAM size
`define RAM_BASE 32'h0000_0000

// Bytes answered by the region
`define REGION_SIZE 1024

// Unmapped space sits above the RAM and ends at REGION_SIZE
// Upper address bits are decoded outside the region through HSEL

`endif

// File: ahbPkg.sv
package ahbPkg;

    // AHB-Lite HTRANS encodings
    typedef enum logic [1:0] {
        IDLE   = 2'b00,             // No transfer
        BUSY   = 2'b01,             // Master inserts a pause
        NONSEQ = 2'b10,             // Single or first beat
        SEQ    = 2'b11              // Following beat
    } htrans_t;

    // Signals of one address phase
    typedef struct packed {
        logic [31:0] addr;          // HADDR
        logic        write;         // HWRITE
        logic [2:0]  size;          // HSIZE
        htrans_t     trans;         // HTRANS
    } ahbAddrPhase_t;

    // Data-phase response of one slave
    typedef struct packed {
        logic [31:0] rdata;         // HRDATA candidate
        logic        readyOut;      // HREADYOUT
        logic        resp;          // High for ERROR
    } ahbSlaveResp_t;

    // Slave that owns a transfer
    typedef enum logic {
        SEL_RAM,
        SEL_DEFAULT
    } slaveSel_t;

    // HSIZE codes used for byte-lane writes
    localparam logic [2:0] sizeByte = 3'b000;
    localparam logic [2:0] sizeHalf = 3'b001;
    localparam logic [2:0] sizeWord = 3'b010;

endpackage

// File: ahbResponseMux.sv
module ahbResponseMux
    import ahbPkg::*;
(
    input  logic          HCLK,
    input  logic          HRESETn,
    input  slaveSel_t     addrOwner,
    input  ahbSlaveResp_t ramResp,
    input  ahbSlaveResp_t defResp,
    output logic [31:0]   HRDATA,
    output logic          HREADY,
    output logic          HRESP
);

    slaveSel_t     dataOwner;       // Slave in the data phase
    ahbSlaveResp_t selResp;

    // Address phase moves into the data phase only on a ready edge
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            dataOwner <= SEL_RAM;
        end else if (HREADY) begin
            dataOwner <= addrOwner;
        end
    end

    always_comb begin
        case (dataOwner)
            SEL_DEFAULT: selResp = defResp;
            SEL_RAM:     selResp = ramResp;
            default:     selResp = ramResp;
        endcase
    end

    assign HRDATA = selResp.rdata;
    assign HREADY = selResp.readyOut;      // Also fed back to the slaves
    assign HRESP  = selResp.resp;

endmodule

// File: ahbWaitRam.sv
`include "ahbMem_config.svh"

module ahbWaitRam
    import ahbPkg::*;
(
    input  logic          HCLK,
    input  logic          HRESETn,
    input  ahbAddrPhase_t addrPhase,
    input  logic          sel,
    input  logic          HREADY,
    input  logic [31:0]   HWDATA,
    output ahbSlaveResp_t resp
);

    localparam int idxWidth  = `RAM_ADDR_WIDTH - 2;
    localparam int wordCount = 2 ** idxWidth;

    typedef enum logic {
        RAM_IDLE,                   // Ready for an address phase
        RAM_ACCESS                  // Wait cycle, memory is touched here
    } ramState_t;

    ramState_t             state;
    logic                  accept;

    // Latched address phase
    logic [idxWidth-1:0]   wordIdx;
    logic [1:0]            byteOff;
    logic [2:0]            sizeLat;
    logic                  writeLat;

    logic [3:0]            laneEn;
    logic [31:0]           rdataReg;
    logic [31:0]           memArray [wordCount];

    assign accept = sel & HREADY;   // Address phase taken on this edge

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state <= RAM_IDLE;
        end else begin
            case (state)
                RAM_IDLE: begin
                    if (accept) begin
                        state <= RAM_ACCESS;
                    end
                end
                RAM_ACCESS: begin
                    state <= RAM_IDLE;     // HREADY is low here, no new phase
                end
                default: begin
                    state <= RAM_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            wordIdx  <= addrPhase.addr[`RAM_ADDR_WIDTH-1:2];
            byteOff  <= addrPhase.addr[1:0];
            sizeLat  <= addrPhase.size;
            writeLat <= addrPhase.write;
        end
    end

    // Byte lanes touched by the latched size and offset
    always_comb begin
        case (sizeLat)
            sizeByte: laneEn = 4'b0001 << byteOff;
            sizeHalf: laneEn = byteOff[1] ? 4'b1100 : 4'b0011;
            sizeWord: laneEn = 4'b1111;
            default:  laneEn = 4'b1111;    // Wider sizes fill the word
        endcase
    end

    // HWDATA is valid and held during the wait cycle
    always_ff @(posedge HCLK) begin
        if (state == RAM_ACCESS) begin
            if (writeLat) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (laneEn[lane]) begin
                        memArray[wordIdx][lane*8 +: 8] <= HWDATA[lane*8 +: 8];
                    end
                end
            end else begin
                rdataReg <= memArray[wordIdx];  // Whole aligned word
            end
        end
    end

    // Ready in IDLE, which is also the second data-phase cycle
    assign resp.rdata    = rdataReg;
    assign resp.readyOut = (state == RAM_IDLE);
    assign resp.resp     = 1'b0;           // RAM never errors

endmodule

// File: files.f
+incdir+.
ahbPkg.sv
ahbAddrDecoder.sv
ahbWaitRam.sv
ahbDefaultSlave.sv
ahbResponseMux.sv
ahbMemSubsystem.sv
tbAhbChecker.sv
tbAhbMem.sv

// File: run.sh
#!/bin/bash
# Build the AHB memory testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbAhbMem -f files.f -o simAhbMem \
    > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/simAhbMem > sim.log 2>&1 \
    || { echo "Simulation exited with an error, see sim.log"; exit 1; }

grep -q "SIMULATION PASSED" sim.log \
    && echo "Run passed, log in sim.log" \
    || { echo "Run failed, see sim.log"; exit 1; }

// File: tbAhbChecker.sv
`include "ahbMem_config.svh"

module tbAhbChecker
    import ahbPkg::*;
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        HSEL,
    input  logic [31:0] HADDR,
    input  logic        HWRITE,
    input  logic [2:0]  HSIZE,
    input  logic [1:0]  HTRANS,
    input  logic [31:0] HWDATA,
    input  logic [31:0] HRDATA,
    input  logic        HREADY,
    input  logic        HRESP,
    input  int          testId,
    output int          phasesChecked,
    output int          valueErrors,
    output int          timingErrors
);

    localparam int ramBytes = 2 ** `RAM_ADDR_WIDTH;

    // Address phase as seen at its accepting edge
    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [2:0]  size;
        logic [1:0]  trans;
        logic        sel;
        logic [7:0]  test;
    } xferRec_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        checkData;     // RAM reads and unmapped phases carry known data
        logic        resp;
        logic [7:0]  waits;
    } expected_t;

    logic [7:0] model [ramBytes];  // Byte image of the RAM
    xferRec_t   pending;
    logic       pendingValid;
    logic [7:0] waitCount;
    logic       respAny;
    logic       respAll;

    function automatic string testName(input logic [7:0] id);
        case (id)
            8'd0:    return "preload";
            8'd1:    return "word write then read";
            8'd2:    return "byte lanes";
            8'd3:    return "unmapped";
            8'd4:    return "unqualified";
            8'd5:    return "random mix";
            default: return "idle";
        endcase
    endfunction

    function automatic logic isQualified(input xferRec_t x);
        return x.sel && (x.trans == NONSEQ || x.trans == SEQ);
    endfunction

    function automatic logic hitsRam(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `RAM_BASE;
        return offset < 32'(ramBytes);
    endfunction

    function automatic logic [31:0] modelWord(input logic [31:0] addr);
        logic [31:0]                word;
        logic [`RAM_ADDR_WIDTH-1:0] idx;
        for (int b = 0; b < 4; b++) begin
            idx = {addr[`RAM_ADDR_WIDTH-1:2], 2'(b)};
            word[b*8 +: 8] = model[idx];
        end
        return word;
    endfunction

    // Expected response of one data phase from the AHB-Lite rules
    function automatic expected_t predict(input xferRec_t x);
        expected_t want;
        want = '0;
        if (!hitsRam(x.addr)) begin
            want.checkData = 1'b1;      // Default slave always returns zero data
        end
        if (isQualified(x)) begin
            want.waits = 8'd1;
            if (!hitsRam(x.addr)) begin
                want.resp = 1'b1;
            end else if (!x.write) begin
                want.checkData = 1'b1;
                want.rdata     = modelWord(x.addr);
            end
        end
        return want;
    endfunction

    task automatic updateModel(input xferRec_t x, input logic [31:0] wdata);
        int                         first;
        int                         count;
        logic [`RAM_ADDR_WIDTH-1:0] idx;
        case (x.size)
            sizeByte: begin
                first = int'(x.addr[1:0]);
                count = 1;
            end
            sizeHalf: begin
                first = x.addr[1] ? 2 : 0;
                count = 2;
            end
            default: begin
                first = 0;
                count = 4;
            end
        endcase
        for (int b = first; b < first + count; b++) begin
            idx = {x.addr[`RAM_ADDR_WIDTH-1:2], 2'(b)};
            model[idx] = wdata[b*8 +: 8];
        end
    endtask

    task automatic completePhase();
        expected_t want;
        string     name;
        want    = predict(pending);
        name    = testName(pending.test);
        respAny = respAny | HRESP;
        respAll = respAll & HRESP;
        if (waitCount != want.waits) begin
            timingErrors++;
            $display("FAIL %s: wait cycles at %h expected %0d actual %0d",
                     name, pending.addr, want.waits, waitCount);
        end
        if (want.resp && respAll !== 1'b1) begin
            valueErrors++;
            $display("FAIL %s: HRESP at %h expected 1 actual %b", name, pending.addr, respAll);
        end
        if (!want.resp && respAny !== 1'b0) begin
            valueErrors++;
            $display("FAIL %s: HRESP at %h expected 0 actual %b", name, pending.addr, respAny);
        end
        if (want.checkData && HRDATA !== want.rdata) begin
            valueErrors++;
            $display("FAIL %s: HRDATA at %h expected %h actual %h",
                     name, pending.addr, want.rdata, HRDATA);
        end
        if (pending.write && isQualified(pending) && hitsRam(pending.addr)) begin
            updateModel(pending, HWDATA);   // HWDATA still held at this edge
        end
        phasesChecked++;
    endtask

    always @(posedge HCLK) begin
        if (!HRESETn) begin
            pendingValid = 1'b0;
        end else if (!HREADY) begin
            if (!pendingValid) begin
                timingErrors++;
                $display("HREADY went low while no transfer was in its data phase");
            end
            waitCount = waitCount + 8'd1;
            respAny   = respAny | HRESP;
            respAll   = respAll & HRESP;
        end else begin
            if (pendingValid) begin
                completePhase();
            end
            pending.addr  = HADDR;          // New address phase enters the data phase
            pending.write = HWRITE;
            pending.size  = HSIZE;
            pending.trans = HTRANS;
            pending.sel   = HSEL;
            pending.test  = 8'(testId);
            pendingValid  = 1'b1;
            waitCount     = 8'd0;
            respAny       = 1'b0;
            respAll       = 1'b1;
        end
    end

endmodule

// File: tbAhbMem.sv
`include "ahbMem_config.svh"

module tbAhbMem
    import ahbPkg::*;
();

    localparam int ramBytes       = 2 ** `RAM_ADDR_WIDTH;
    localparam int regionBytes    = `REGION_SIZE;
    localparam int resetCycles    = 16;
    localparam int preloadCount   = ramBytes / 4;   // One write per RAM word
    localparam int pairCount      = 16;
    localparam int laneCount      = 16;
    localparam int unmappedCount  = 12;
    localparam int checkReads     = 8;
    localparam int unqualCount    = 16;
    localparam int mixCount       = 300;
    localparam int totalTransfers = preloadCount + 2 * pairCount + 2 * laneCount
                                  + unmappedCount + checkReads + 2 * unqualCount
                                  + mixCount + 2;
    // Two data-phase cycles plus at most two idle gap cycles per transfer
    localparam int timeoutLimit   = totalTransfers * 4 + resetCycles + 200;

    logic        HCLK = 1'b0;
    logic        HRESETn;
    logic        HSEL;
    logic [31:0] HADDR;
    logic        HWRITE;
    logic [2:0]  HSIZE;
    logic [1:0]  HTRANS;
    logic [31:0] HWDATA;
    logic [31:0] HRDATA;
    logic        HREADY;
    logic        HRESP;

    int          testId;
    int          phasesChecked;
    int          valueErrors;
    int          timingErrors;
    int          cycleCount;
    logic [31:0] rngState = 32'h1dd8_3217;
    logic [31:0] addrList [$];

    ahbMemSubsystem uut (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .HSEL    (HSEL),
        .HADDR   (HADDR),
        .HWRITE  (HWRITE),
        .HSIZE   (HSIZE),
        .HTRANS  (HTRANS),
        .HWDATA  (HWDATA),
        .HRDATA  (HRDATA),
        .HREADY  (HREADY),
        .HRESP   (HRESP)
    );

    tbAhbChecker respCheck (
        .HCLK          (HCLK),
        .HRESETn       (HRESETn),
        .HSEL          (HSEL),
        .HADDR         (HADDR),
        .HWRITE        (HWRITE),
        .HSIZE         (HSIZE),
        .HTRANS        (HTRANS),
        .HWDATA        (HWDATA),
        .HRDATA        (HRDATA),
        .HREADY        (HREADY),
        .HRESP         (HRESP),
        .testId        (testId),
        .phasesChecked (phasesChecked),
        .valueErrors   (valueErrors),
        .timingErrors  (timingErrors)
    );

    initial begin
        forever #4 HCLK = ~HCLK;
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] randBelow(input logic [31:0] limit);
        return nextRand() % limit;
    endfunction

    function automatic logic [31:0] ramWordAddr();
        return `RAM_BASE + (randBelow(32'(ramBytes / 4)) << 2);
    endfunction

    function automatic logic [31:0] unmappedAddr();
        logic [31:0] span;
        span = 32'(regionBytes) - `RAM_BASE - 32'(ramBytes);
        return (`RAM_BASE + 32'(ramBytes) + randBelow(span)) & ~32'd3;
    endfunction

    function automatic logic [31:0] alignAddr(input logic [31:0] addr, input logic [2:0] size);
        case (size)
            sizeByte: return addr;
            sizeHalf: return {addr[31:1], 1'b0};
            default:  return {addr[31:2], 2'b00};
        endcase
    endfunction

    // Address phase at a falling edge, held until HREADY lets it through
    task automatic issue(input logic selIn, input htrans_t transIn, input logic [31:0] addrIn,
                         input logic writeIn, input logic [2:0] sizeIn,
                         input logic [31:0] dataIn);
        HSEL   = selIn;
        HTRANS = transIn;
        HADDR  = addrIn;
        HWRITE = writeIn;
        HSIZE  = sizeIn;
        while (!HREADY) begin
            @(negedge HCLK);
        end
        @(negedge HCLK);
        HWDATA = dataIn;            // Data phase of this transfer starts
    endtask

    task automatic writeXfer(input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
        issue(1'b1, NONSEQ, addr, 1'b1, size, data);
    endtask

    task automatic readXfer(input logic [31:0] addr);
        issue(1'b1, NONSEQ, addr, 1'b0, sizeWord, nextRand());
    endtask

    task automatic idleXfer();
        issue(1'b1, IDLE, randBelow(32'(regionBytes)) & ~32'd3, 1'b0, sizeWord, nextRand());
    endtask

    task automatic randomGap();
        int gap;
        gap = int'(randBelow(32'd3));
        repeat (gap) idleXfer();
    endtask

    task automatic runPreload();
        for (int i = 0; i < preloadCount; i++) begin
            writeXfer(`RAM_BASE + 32'(i * 4), sizeWord, nextRand());
        end
    endtask

    task automatic runWordTest();
        logic [31:0] addr;
        addrList.delete();
        for (int i = 0; i < pairCount; i++) begin
            addr = ramWordAddr();
            addrList.push_back(addr);
            writeXfer(addr, sizeWord, nextRand());
            randomGap();
        end
        foreach (addrList[i]) begin
            readXfer(addrList[i]);
            randomGap();
        end
    endtask

    task automatic runLaneTest();
        logic [31:0] addr;
        logic [2:0]  size;
        for (int i = 0; i < laneCount; i++) begin
            size = 3'(randBelow(32'd2));   // Byte or halfword
            addr = alignAddr(`RAM_BASE + randBelow(32'(ramBytes)), size);
            writeXfer(addr, size, nextRand());
            readXfer({addr[31:2], 2'b00});
            randomGap();
        end
    endtask

    task automatic runUnmappedTest();
        for (int i = 0; i < unmappedCount; i++) begin
            if (randBelow(32'd2) == 32'd0) begin
                writeXfer(unmappedAddr(), sizeWord, nextRand());
            end else begin
                readXfer(unmappedAddr());
            end
            randomGap();
        end
        for (int i = 0; i < checkReads; i++) begin
            readXfer(ramWordAddr());      // RAM must be untouched
        end
    endtask

    task automatic runUnqualTest();
        logic [31:0] addr;
        addrList.delete();
        for (int i = 0; i < unqualCount; i++) begin
            addr = ramWordAddr();
            addrList.push_back(addr);
            case (randBelow(32'd3))
                32'd0:   issue(1'b1, IDLE, addr, 1'b1, sizeWord, nextRand());
                32'd1:   issue(1'b1, BUSY, addr, 1'b1, sizeWord, nextRand());
                default: issue(1'b0, NONSEQ, addr, 1'b1, sizeWord, nextRand());
            endcase
            randomGap();
        end
        foreach (addrList[i]) begin
            readXfer(addrList[i]);
        end
    endtask

    task automatic runMixTest();
        logic [31:0] addr;
        logic [2:0]  size;
        htrans_t     trans;
        for (int i = 0; i < mixCount; i++) begin
            trans = (randBelow(32'd2) == 32'd0) ? NONSEQ : SEQ;
            case (randBelow(32'd8))
                32'd0, 32'd1, 32'd2: begin
                    issue(1'b1, trans, ramWordAddr(), 1'b0, sizeWord, nextRand());
                end
                32'd3: issue(1'b1, trans, ramWordAddr(), 1'b1, sizeWord, nextRand());
                32'd4: begin
                    size = 3'(randBelow(32'd2));
                    addr = alignAddr(`RAM_BASE + randBelow(32'(ramBytes)), size);
                    issue(1'b1, trans, addr, 1'b1, size, nextRand());
                end
                32'd5: begin
                    issue(1'b1, trans, unmappedAddr(), randBelow(32'd2) == 32'd0, sizeWord,
                          nextRand());
                end
                32'd6: begin
                    trans = (randBelow(32'd2) == 32'd0) ? IDLE : BUSY;
                    issue(1'b1, trans, ramWordAddr(), 1'b1, sizeWord, nextRand());
                end
                default: issue(1'b0, trans, ramWordAddr(), 1'b1, sizeWord, nextRand());
            endcase
        end
    endtask

    initial begin
        HRESETn = 1'b0;
        HSEL    = 1'b0;
        HADDR   = '0;
        HWRITE  = 1'b0;
        HSIZE   = sizeWord;
        HTRANS  = IDLE;
        HWDATA  = '0;
        testId  = 6;
        repeat (resetCycles) @(negedge HCLK);
        HRESETn = 1'b1;
        testId = 0;
        runPreload();
        testId = 1;
        runWordTest();
        testId = 2;
        runLaneTest();
        testId = 3;
        runUnmappedTest();
        testId = 4;
        runUnqualTest();
        testId = 5;
        runMixTest();
        testId = 6;
        repeat (2) idleXfer();     // Let the last data phase complete
        repeat (2) @(negedge HCLK);
        $display("Data phases checked: %0d, value errors: %0d, timing errors: %0d",
                 phasesChecked, valueErrors, timingErrors);
        if (valueErrors + timingErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutLimit) begin
            @(posedge HCLK);
            cycleCount++;
        end
        $display("ERROR: run stopped after %0d cycles, the transfers did not complete",
                 cycleCount);
        $display("Data phases checked: %0d, value errors: %0d, timing errors: %0d",
                 phasesChecked, valueErrors, timingErrors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
